// ==== logic/vga_timing_pkg.sv ====
// raster scan phase encoding and counter widths used by the sync generator
package vga_timing_pkg;

    ////////////////////////////////////////////////////////////
    // counter widths
    ////////////////////////////////////////////////////////////

    localparam int H_COUNT_BITS = 10;  // up to 1023 cycles per phase
    localparam int V_COUNT_BITS = 9;   // up to 511 lines per phase

    // horizontal cycle counter
    typedef logic [H_COUNT_BITS-1:0] h_count_t;

    // vertical line counter
    typedef logic [V_COUNT_BITS-1:0] v_count_t;

    ////////////////////////////////////////////////////////////
    // scan phases, same order on both axes
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        PH_SYNC   = 2'b00,  // sync pulse, level low
        PH_BACK   = 2'b01,  // back porch
        PH_ACTIVE = 2'b10,  // visible region
        PH_FRONT  = 2'b11   // front porch, wraps to sync
    } scan_phase_t;

endpackage

// ==== logic/frame_buffer_pkg.sv ====
// frame buffer word, address and screen geometry constants
package frame_buffer_pkg;

    ////////////////////////////////////////////////////////////
    // storage shape
    ////////////////////////////////////////////////////////////

    localparam int FB_WORD_BITS     = 32;  // one bit per pixel
    localparam int FB_WORDS_PER_ROW = 4;
    localparam int FB_ROWS          = 96;
    localparam int FB_DEPTH         = FB_WORDS_PER_ROW * FB_ROWS;  // 384 words
    localparam int FB_ADDR_BITS     = $clog2(FB_DEPTH);

    typedef logic [FB_WORD_BITS-1:0] fb_word_t;
    typedef logic [FB_ADDR_BITS-1:0] fb_addr_t;

    ////////////////////////////////////////////////////////////
    // pixel stretching on screen
    ////////////////////////////////////////////////////////////

    localparam int PIXEL_REPEAT = 2;  // cycles per bit
    localparam int LINE_REPEAT  = 4;  // lines per word row

    // active cycles carrying buffer data, 256
    localparam int DISPLAY_COLS  = FB_WORDS_PER_ROW * FB_WORD_BITS * PIXEL_REPEAT;
    // active lines carrying buffer data, 384
    localparam int DISPLAY_LINES = FB_ROWS * LINE_REPEAT;

endpackage

// ==== logic/sync_timing_gen.sv ====
// raster sync generator with horizontal and vertical phase counters and display window
`timescale 1ns/1ps

module sync_timing_gen
    import frame_buffer_pkg::*;
    import vga_timing_pkg::*;
#(
    parameter int H_SYNC   = 46,   // cycles
    parameter int H_BACK   = 23,
    parameter int H_ACTIVE = 305,
    parameter int H_FRONT  = 8,
    parameter int V_SYNC   = 3,    // lines
    parameter int V_BACK   = 34,
    parameter int V_ACTIVE = 481,
    parameter int V_FRONT  = 11
) (
    input  logic     clk,
    input  logic     nrst,
    output logic     h_sync_raw,  // low during h sync
    output logic     v_sync_raw,  // low during v sync
    output logic     in_display,  // inside the data window
    output h_count_t h_pos,
    output v_count_t v_pos
);

    scan_phase_t h_phase;
    scan_phase_t h_phase_next;
    scan_phase_t v_phase;
    scan_phase_t v_phase_next;
    h_count_t    h_cnt;
    h_count_t    h_len;     // length of current h phase
    v_count_t    v_cnt;
    v_count_t    v_len;
    logic        h_last;    // last cycle of current h phase
    logic        line_end;  // last cycle of the whole line
    logic        v_last;    // last cycle of last line in v phase

    // sync -> back -> active -> front -> sync
    function automatic scan_phase_t step_phase(input scan_phase_t ph);
        scan_phase_t nxt;
        case (ph)
            PH_SYNC:   nxt = PH_BACK;
            PH_BACK:   nxt = PH_ACTIVE;
            PH_ACTIVE: nxt = PH_FRONT;
            default:   nxt = PH_SYNC;
        endcase
        return nxt;
    endfunction

    ////////////////////////////////////////////////////////////
    // horizontal machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (h_phase)
            PH_SYNC:   h_len = h_count_t'(H_SYNC);
            PH_BACK:   h_len = h_count_t'(H_BACK);
            PH_ACTIVE: h_len = h_count_t'(H_ACTIVE);
            default:   h_len = h_count_t'(H_FRONT);
        endcase
    end

    assign h_last       = (h_cnt == h_len - 1'b1);
    assign line_end     = h_last && (h_phase == PH_FRONT);
    assign h_phase_next = h_last ? step_phase(h_phase) : h_phase;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            h_phase    <= PH_SYNC;  // start of h sync
            h_cnt      <= '0;
            h_sync_raw <= 1'b0;
        end else begin
            h_phase    <= h_phase_next;
            h_cnt      <= h_last ? '0 : h_cnt + 1'b1;
            h_sync_raw <= (h_phase_next != PH_SYNC);  // tracks the phase register
        end
    end

    ////////////////////////////////////////////////////////////
    // vertical machine stepping once per line
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (v_phase)
            PH_SYNC:   v_len = v_count_t'(V_SYNC);
            PH_BACK:   v_len = v_count_t'(V_BACK);
            PH_ACTIVE: v_len = v_count_t'(V_ACTIVE);
            default:   v_len = v_count_t'(V_FRONT);
        endcase
    end

    assign v_last       = line_end && (v_cnt == v_len - 1'b1);
    assign v_phase_next = v_last ? step_phase(v_phase) : v_phase;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            v_phase    <= PH_SYNC;  // first sync line
            v_cnt      <= '0;
            v_sync_raw <= 1'b0;
        end else begin
            v_phase    <= v_phase_next;
            if (line_end) begin
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end
            v_sync_raw <= (v_phase_next != PH_SYNC);
        end
    end

    // data window sits at the top left of the active area
    assign in_display = (h_phase == PH_ACTIVE) && (v_phase == PH_ACTIVE)
                     && (h_cnt < h_count_t'(DISPLAY_COLS))
                     && (v_cnt < v_count_t'(DISPLAY_LINES));

    assign h_pos = h_cnt;  // meaningful only while active
    assign v_pos = v_cnt;

    // each counter stays inside the phase it belongs to
    a_h_cnt_bound: assert property (@(posedge clk) disable iff (!nrst) h_cnt < h_len)
        else $error("h counter past end of phase");
    a_v_cnt_bound: assert property (@(posedge clk) disable iff (!nrst) v_cnt < v_len)
        else $error("v counter past end of phase");

endmodule

// ==== logic/frame_buffer_ram.sv ====
// frame buffer memory with one write port and one registered read port
`timescale 1ns/1ps

module frame_buffer_ram
    import frame_buffer_pkg::*;
(
    input  logic     clk,
    input  logic     wr_en,    // one word per high cycle
    input  fb_addr_t wr_addr,
    input  fb_word_t wr_data,
    input  fb_addr_t rd_addr,  // from the scanner, every cycle
    output fb_word_t rd_data   // valid one cycle after rd_addr
);

    fb_word_t mem [FB_DEPTH];  // 32 screen pixels per word

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    // same-address collision returns the word before the write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // writer must stay inside the 384 words
    a_wr_range: assert property (@(posedge clk) wr_en |-> (wr_addr < fb_addr_t'(FB_DEPTH)))
        else $error("write address %0d out of range", wr_addr);

    // scanner address is forced to zero outside the window
    a_rd_range: assert property (@(posedge clk) rd_addr < fb_addr_t'(FB_DEPTH))
        else $error("read address %0d out of range", rd_addr);

endmodule

// ==== logic/pixel_scanner.sv ====
// pixel fetch, turns screen position into buffer address and serialises the word
`timescale 1ns/1ps

module pixel_scanner
    import frame_buffer_pkg::*;
    import vga_timing_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     h_sync_raw,
    input  logic     v_sync_raw,
    input  logic     in_display,
    input  h_count_t h_pos,
    input  v_count_t v_pos,
    input  fb_word_t rd_data,     // word for the previous cycle's address
    output fb_addr_t rd_addr,
    output logic     h_out,
    output logic     v_out,
    output logic     pixel_data
);

    localparam int WORD_SPAN    = FB_WORD_BITS * PIXEL_REPEAT;  // cycles per word
    localparam int BIT_IDX_BITS = $clog2(FB_WORD_BITS);

    v_count_t                word_row;   // buffer row for this line
    h_count_t                word_col;   // word within the row
    logic [BIT_IDX_BITS-1:0] bit_idx;    // bit to show, msb first
    logic [BIT_IDX_BITS-1:0] bit_idx_q;
    logic                    disp_q;     // in_display one cycle late

    ////////////////////////////////////////////////////////////
    // address generation
    ////////////////////////////////////////////////////////////

    always_comb begin
        word_row = v_pos / v_count_t'(LINE_REPEAT);  // 4 lines share a row
        word_col = h_pos / h_count_t'(WORD_SPAN);    // 64 cycles per word
    end

    // parked at word 0 outside the window, keeps the address legal
    assign rd_addr = in_display
                   ? fb_addr_t'(word_row * FB_WORDS_PER_ROW + word_col)
                   : '0;

    // msb first, each bit held PIXEL_REPEAT cycles
    assign bit_idx = BIT_IDX_BITS'(FB_WORD_BITS - 1
                                   - ((h_pos / PIXEL_REPEAT) % FB_WORD_BITS));

    ////////////////////////////////////////////////////////////
    // alignment stage
    ////////////////////////////////////////////////////////////

    // matches the ram read latency so syncs and data leave together
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            h_out     <= 1'b0;  // reset lands in sync on both axes
            v_out     <= 1'b0;
            disp_q    <= 1'b0;
            bit_idx_q <= '0;
        end else begin
            h_out     <= h_sync_raw;
            v_out     <= v_sync_raw;
            disp_q    <= in_display;
            bit_idx_q <= bit_idx;
        end
    end

    // blank outside the data window
    assign pixel_data = disp_q & rd_data[bit_idx_q];

endmodule

// ==== logic/mono_vga_top.sv ====
// monochrome raster display top, sync timing plus frame buffer plus pixel fetch
`timescale 1ns/1ps

module mono_vga_top
    import frame_buffer_pkg::*;
    import vga_timing_pkg::*;
#(
    parameter int H_SYNC   = 46,   // cycles per h phase
    parameter int H_BACK   = 23,
    parameter int H_ACTIVE = 305,  // at least DISPLAY_COLS
    parameter int H_FRONT  = 8,
    parameter int V_SYNC   = 3,    // lines per v phase
    parameter int V_BACK   = 34,
    parameter int V_ACTIVE = 481,  // at least DISPLAY_LINES
    parameter int V_FRONT  = 11
) (
    input  logic     clk,
    input  logic     nrst,
    input  logic     wr_en,       // store strobe, no back-pressure
    input  fb_addr_t wr_addr,
    input  fb_word_t wr_data,
    output logic     h_out,       // to the connector
    output logic     v_out,
    output logic     pixel_data
);

    logic     h_sync_raw;
    logic     v_sync_raw;
    logic     in_display;
    h_count_t h_pos;
    v_count_t v_pos;
    fb_addr_t rd_addr;
    fb_word_t rd_data;

    ////////////////////////////////////////////////////////////
    // timing, memory, fetch
    ////////////////////////////////////////////////////////////

    sync_timing_gen #(
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT)
    ) i_timing (
        .clk        (clk),
        .nrst       (nrst),
        .h_sync_raw (h_sync_raw),
        .v_sync_raw (v_sync_raw),
        .in_display (in_display),
        .h_pos      (h_pos),
        .v_pos      (v_pos)
    );

    frame_buffer_ram i_fb (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // one cycle behind the counters, same as the ram read
    pixel_scanner i_scan (
        .clk        (clk),
        .nrst       (nrst),
        .h_sync_raw (h_sync_raw),
        .v_sync_raw (v_sync_raw),
        .in_display (in_display),
        .h_pos      (h_pos),
        .v_pos      (v_pos),
        .rd_data    (rd_data),
        .rd_addr    (rd_addr),
        .h_out      (h_out),
        .v_out      (v_out),
        .pixel_data (pixel_data)
    );

endmodule

// ==== include/tb_vga_checks.svh ====
// compare helpers for the display testbench, the first mismatch ends the run
`ifndef TB_VGA_CHECKS_SVH
`define TB_VGA_CHECKS_SVH

////////////////////////////////////////////////////////////
// common fail path
////////////////////////////////////////////////////////////

// needs vga_timing_pkg imported before inclusion
task automatic report_check_failure(
    input string test_name,
    input string what,
    input string expected,
    input string actual
);
    $display("CHECK FAILED test=%s %s expected=%s actual=%s",
             test_name, what, expected, actual);
    $display("Simulation failed");
    $fatal(1, "%s mismatch in %s", what, test_name);
endtask

////////////////////////////////////////////////////////////
// typed compares
////////////////////////////////////////////////////////////

// single output level, x or z counts as a mismatch
task automatic check_level(
    input string test_name,
    input string what,
    input logic  expected,
    input logic  actual
);
    if (actual !== expected) begin
        report_check_failure(test_name, what,
                             $sformatf("%b", expected), $sformatf("%b", actual));
    end
endtask

// run lengths and line periods in cycles
task automatic check_count(
    input string    test_name,
    input string    what,
    input h_count_t expected,
    input h_count_t actual
);
    if (actual !== expected) begin
        report_check_failure(test_name, what,
                             $sformatf("%0d", expected), $sformatf("%0d", actual));
    end
endtask

`endif

// ==== tests/tb_mono_vga_top.sv ====
// testbench for the monochrome raster display that writes buffer blocks and checks whole frames
`timescale 1ns/1ps

module tb_mono_vga_top
    import frame_buffer_pkg::*;
    import vga_timing_pkg::*;
;

    localparam int H_SYNC   = 4;    // 269 cycle line
    localparam int H_BACK   = 3;
    localparam int H_ACTIVE = 260;
    localparam int H_FRONT  = 2;
    localparam int V_SYNC   = 2;    // 391 line frame
    localparam int V_BACK   = 2;
    localparam int V_ACTIVE = 386;
    localparam int V_FRONT  = 1;

    localparam int LINE_CYCLES    = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
    localparam int FRAME_LINES    = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = (NUM_TESTS + 2) * FRAME_LINES * LINE_CYCLES + RESET_CYCLES;

    typedef enum int {MODE_ONES, MODE_ZEROS, MODE_ALT, MODE_RAND} data_mode_t;

    ////////////////////////////////////////////////////////////
    // stimulus table with one buffer block per row
    ////////////////////////////////////////////////////////////

    string      test_names  [NUM_TESTS] = '{"clear_all", "top_rows_ones", "alt_middle",
                                            "random_block", "zero_patch", "random_tail"};
    int         start_addrs [NUM_TESTS] = '{0, 0, 100, 37, 200, 300};
    int         word_counts [NUM_TESTS] = '{384, 64, 80, 150, 20, 84};  // last row ends at 383
    data_mode_t data_modes  [NUM_TESTS] = '{MODE_ZEROS, MODE_ONES, MODE_ALT,
                                            MODE_RAND, MODE_ZEROS, MODE_RAND};

    logic     clk = 1'b0;
    logic     nrst;
    logic     wr_en;
    fb_addr_t wr_addr;
    fb_word_t wr_data;
    logic     h_out;
    logic     v_out;
    logic     pixel_data;

    fb_word_t model [FB_DEPTH];  // expected buffer contents
    integer   seed = 32'ha35e37e5;
    string    cur_test = "reset";
    int       cycle_count = 0;
    int       frame_starts = 0;  // v_out falling edges seen

    // monitor state in output time
    logic prev_h = 1'b0;
    logic prev_v = 1'b0;
    logic h_seen = 1'b0;  // a falling edge of h_out was seen
    logic locked = 1'b0;  // frame position known
    int   tick = 0;
    int   last_fall = 0;
    int   low_len = 0;
    int   since_rise = 0;
    int   line_idx = 0;

    `include "tb_vga_checks.svh"

    mono_vga_top #(
        .H_SYNC (H_SYNC), .H_BACK (H_BACK), .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT),
        .V_SYNC (V_SYNC), .V_BACK (V_BACK), .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT)
    ) i_dut (
        .clk        (clk),
        .nrst       (nrst),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .h_out      (h_out),
        .v_out      (v_out),
        .pixel_data (pixel_data)
    );

    always #50 clk = ~clk;  // 100 ns period

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, frame never completed");
            $display("Simulation failed");
            $fatal(1, "cycle limit of %0d reached", TIMEOUT_CYCLES);
        end
    end

    ////////////////////////////////////////////////////////////
    // output monitor sampling at the falling edge
    ////////////////////////////////////////////////////////////

    task automatic track_outputs();
        logic h_fall;
        logic h_rise;
        logic exp_pix;
        int   l;
        int   c;
        int   word_idx;
        int   bit_sel;
        h_fall = prev_h && !h_out;
        h_rise = !prev_h && h_out;
        tick++;
        if (prev_v != v_out) begin  // v edges only at line starts
            check_level(cur_test, "h_out fall at v_out edge", 1'b1, h_fall);
        end
        if (h_fall) begin
            if (h_seen) begin
                check_count(cur_test, "h_out fall period", h_count_t'(LINE_CYCLES),
                            h_count_t'(tick - last_fall));
            end
            h_seen    = 1'b1;
            last_fall = tick;
            low_len   = 0;
            if (prev_v && !v_out) begin  // new frame
                if (locked) begin
                    check_count(cur_test, "lines per frame", h_count_t'(FRAME_LINES),
                                h_count_t'(line_idx + 1));
                end
                locked   = 1'b1;
                line_idx = 0;
                frame_starts++;
            end else begin
                line_idx++;
                if (locked && line_idx == FRAME_LINES) begin
                    check_count(cur_test, "lines per frame", h_count_t'(FRAME_LINES),
                                h_count_t'(line_idx + 1));
                end
            end
            if (locked) begin
                check_level(cur_test, "v_out at line start", line_idx >= V_SYNC, v_out);
            end
        end
        if (!h_out) low_len++;
        if (h_rise) begin
            if (h_seen) begin
                check_count(cur_test, "h_out low run", h_count_t'(H_SYNC), h_count_t'(low_len));
            end
            since_rise = 0;
        end else begin
            since_rise++;
        end
        if (locked) begin
            exp_pix = 1'b0;  // blank unless inside the data window
            l = line_idx - V_SYNC - V_BACK;
            c = since_rise - H_BACK;
            if (h_out && l >= 0 && l < DISPLAY_LINES && c >= 0 && c < DISPLAY_COLS) begin
                word_idx = (l / LINE_REPEAT) * FB_WORDS_PER_ROW
                         + c / (FB_WORD_BITS * PIXEL_REPEAT);
                bit_sel  = FB_WORD_BITS - 1 - (c / PIXEL_REPEAT) % FB_WORD_BITS;  // msb first
                exp_pix  = model[word_idx][bit_sel];
            end
            check_level(cur_test, "pixel_data", exp_pix, pixel_data);
        end
        prev_h = h_out;
        prev_v = v_out;
    endtask

    always @(negedge clk) begin
        if (nrst) track_outputs();
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // consecutive stores at one per cycle with the model kept in step
    task automatic write_block(input int first, input int count, input data_mode_t mode);
        fb_word_t word;
        for (int i = 0; i < count; i++) begin
            case (mode)
                MODE_ONES:  word = '1;
                MODE_ZEROS: word = '0;
                MODE_ALT:   word = (i % 2 == 0) ? 32'haaaa_aaaa : 32'h5555_5555;
                default:    word = fb_word_t'($random(seed));
            endcase
            @(posedge clk);
            #1;
            wr_en   = 1'b1;
            wr_addr = fb_addr_t'(first + i);
            wr_data = word;
            model[first + i] = word;
        end
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    task automatic wait_frame_start();
        int seen;
        seen = frame_starts;
        wait (frame_starts != seen);
    endtask

    initial begin
        nrst    = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        for (int i = 0; i < FB_DEPTH; i++) model[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_level("reset", "h_out", 1'b0, h_out);
        check_level("reset", "v_out", 1'b0, v_out);
        @(posedge clk);
        #1;
        nrst = 1'b1;
        @(negedge clk);  // first cycle out of reset is still in both syncs
        check_level("reset", "h_out", 1'b0, h_out);
        check_level("reset", "v_out", 1'b0, v_out);
        wait_frame_start();  // first frame after reset is unchecked
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_test = test_names[t];
            write_block(start_addrs[t], word_counts[t], data_modes[t]);  // inside v sync
            wait_frame_start();
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
logic/vga_timing_pkg.sv
logic/frame_buffer_pkg.sv
logic/sync_timing_gen.sv
logic/frame_buffer_ram.sv
logic/pixel_scanner.sv
logic/mono_vga_top.sv
tests/tb_mono_vga_top.sv

// ==== Makefile ====
# Verilator build for the monochrome raster display testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mono_vga_top
FILELIST  := all.f
BUILD_DIR := obj_dir

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard logic/*.sv) $(wildcard tests/*.sv) $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
